//--- common/lane_buf_params.svh
`ifndef LANE_BUF_PARAMS_SVH
`define LANE_BUF_PARAMS_SVH

// ==========================================================================
// Lane geometry
// ==========================================================================

// Byte lanes per word
`define LANE_COUNT 4

// Bits held by one lane
`define LANE_W 8

// Entries in each lane array
`define LANE_DEPTH 512

// Lane address width, sized to the depth
`define LANE_AW 9

// Full word, one byte per lane
`define WORD_W (`LANE_COUNT * `LANE_W)

`endif

//--- common/lane_buf_cmd_pkg.sv
`default_nettype none

`include "lane_buf_params.svh"

package lane_buf_cmd_pkg;

    // Host opcodes, encoding 2'b11 unused
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FILL  = 2'd2
    } buf_op_e;

    // One host command, as latched when req is accepted
    typedef struct packed {
        buf_op_e                 op;
        // Start word address
        logic [`LANE_AW-1:0]     addr;
        // Write word, also the fill pattern
        logic [`WORD_W-1:0]      wdata;
        // One enable bit per byte lane
        logic [`LANE_COUNT-1:0]  byte_en;
        // Fill length, 0 up to LANE_DEPTH words
        logic [`LANE_AW:0]       len;
    } buf_cmd_t;

endpackage

`default_nettype wire

//--- common/lane_buf_ctrl_pkg.sv
`default_nettype none

package lane_buf_ctrl_pkg;

    // Controller FSM states
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_EXEC    = 3'd1,
        ST_FILL    = 3'd2,
        ST_ACK     = 3'd3,
        ST_RELEASE = 3'd4
    } ctrl_state_e;

    // Kind of lane access in the current cycle
    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_RD   = 2'd1,
        LANE_WR   = 2'd2
    } lane_phase_t;

endpackage

`default_nettype wire

//--- common/lane_mem_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "lane_buf_params.svh"

interface lane_mem_if
    import lane_buf_ctrl_pkg::*;
();

    // Per-lane address, one slot per lane
    logic [`LANE_COUNT-1:0][`LANE_AW-1:0] addr;

    // Per-lane write byte
    logic [`LANE_COUNT-1:0][`LANE_W-1:0]  wdata;

    // Per-lane write enable, write lands on the clock edge
    logic [`LANE_COUNT-1:0]               we;

    // Per-lane read byte, follows addr in the same cycle
    logic [`LANE_COUNT-1:0][`LANE_W-1:0]  rdata;

    // Access kind shared by all lanes this cycle
    lane_phase_t                          phase;

    // Controller side
    modport ctrl (
        output addr, wdata, we, phase,
        input  rdata
    );

    // Memory side, mirror of ctrl
    modport mem (
        input  addr, wdata, we, phase,
        output rdata
    );

endinterface

`default_nettype wire

//--- memory/quad_port_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "lane_buf_params.svh"

module quad_port_ram
    import lane_buf_ctrl_pkg::*;
(
    input logic     i_clk,
    // Only used to hold off the checks during reset
    input logic     rst,
    lane_mem_if.mem mem
);

    // ==========================================================================
    // Byte lanes
    // ==========================================================================

    // One single-port array per lane, each with its own address
    for (genvar g = 0; g < `LANE_COUNT; g++) begin : g_lane

        // LANE_DEPTH bytes, contents undefined until written
        logic [`LANE_W-1:0] lane_ram [0:`LANE_DEPTH-1];

        // Synchronous write
        always_ff @(posedge i_clk) begin
            if (mem.we[g]) begin
                lane_ram[mem.addr[g]] <= mem.wdata[g];
            end
        end

        // Combinational read from the same address
        assign mem.rdata[g] = lane_ram[mem.addr[g]];

        // ======================================================================
        // Lane checks
        // ======================================================================

        // Enable must be a clean 0 or 1 once out of reset
        a_we_known: assert property (
            @(posedge i_clk) disable iff (rst)
            !$isunknown(mem.we[g])
        ) else $error("lane %0d write enable unknown", g);

        // Written address stays inside the array
        a_wr_addr_range: assert property (
            @(posedge i_clk) disable iff (rst)
            mem.we[g] |-> (int'(mem.addr[g]) < `LANE_DEPTH)
        ) else $error("lane %0d write address %0d out of range", g, mem.addr[g]);

        // A lane only writes while the controller signals a write phase
        a_we_in_wr_phase: assert property (
            @(posedge i_clk) disable iff (rst)
            mem.we[g] |-> (mem.phase == LANE_WR)
        ) else $error("lane %0d written outside a write phase", g);

    end

endmodule

`default_nettype wire

//--- design/lane_buf_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "lane_buf_params.svh"

module lane_buf_ctrl
    import lane_buf_cmd_pkg::*, lane_buf_ctrl_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   rst,
    // Host side, four-phase req/ack
    input  logic                   req,
    output logic                   ack,
    input  buf_op_e                op,
    input  logic [`LANE_AW-1:0]    addr,
    input  logic [`WORD_W-1:0]     wdata,
    input  logic [`LANE_COUNT-1:0] byte_en,
    input  logic [`LANE_AW:0]      len,
    output logic [`WORD_W-1:0]     rdata,
    // Lane side
    lane_mem_if.ctrl               mem
);

    // Remaining count on the final fill word
    localparam logic [`LANE_AW:0] LAST_WORD = 1;

    ctrl_state_e          state;
    // Latched command, addr and len also step during a fill
    buf_cmd_t             cmd;
    // Lane bytes gathered into one word
    logic [`WORD_W-1:0]   lane_word;

    // ==========================================================================
    // Command register
    // ==========================================================================

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && req) begin
            cmd.op      <= op;
            cmd.addr    <= addr;
            cmd.wdata   <= wdata;
            cmd.byte_en <= byte_en;
            cmd.len     <= len;
        end else if (state == ST_FILL) begin
            // Address wraps modulo LANE_DEPTH by its width
            cmd.addr <= cmd.addr + 1'b1;
            cmd.len  <= cmd.len - 1'b1;
        end
    end

    // ==========================================================================
    // FSM, ack and read data
    // ==========================================================================

    always_ff @(posedge i_clk) begin
        if (rst) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
            rdata <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        // Zero-length fill has nothing to write
                        if (op != OP_FILL) begin
                            state <= ST_EXEC;
                        end else if (len == '0) begin
                            state <= ST_ACK;
                        end else begin
                            state <= ST_FILL;
                        end
                    end
                end
                ST_EXEC: begin
                    // Single word access happens on this edge
                    if (cmd.op == OP_READ) begin
                        rdata <= lane_word;
                    end
                    state <= ST_ACK;
                end
                ST_FILL: begin
                    if (cmd.len == LAST_WORD) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // Hold ack while the host keeps req up
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ==========================================================================
    // Lane drive
    // ==========================================================================

    always_comb begin
        mem.phase = LANE_IDLE;
        mem.we    = '0;
        for (int i = 0; i < `LANE_COUNT; i++) begin
            // All lanes share one word address
            mem.addr[i]  = cmd.addr;
            mem.wdata[i] = cmd.wdata[i*`LANE_W +: `LANE_W];
            lane_word[i*`LANE_W +: `LANE_W] = mem.rdata[i];
        end
        case (state)
            ST_EXEC: begin
                if (cmd.op == OP_WRITE) begin
                    // Masked lanes keep their old byte
                    mem.phase = LANE_WR;
                    mem.we    = cmd.byte_en;
                end else begin
                    mem.phase = LANE_RD;
                end
            end
            ST_FILL: begin
                mem.phase = LANE_WR;
                mem.we    = '1;
            end
            default: begin
                mem.phase = LANE_IDLE;
            end
        endcase
    end

    // ==========================================================================
    // Handshake checks
    // ==========================================================================

    // ack only goes up in answer to a held req
    a_ack_rise_on_req: assert property (
        @(posedge i_clk) disable iff (rst)
        $rose(ack) |-> $past(req)
    ) else $error("ack rose without req");

    // Lanes stay quiet outside the access states
    a_we_only_in_access: assert property (
        @(posedge i_clk) disable iff (rst)
        !(state inside {ST_EXEC, ST_FILL}) |-> (mem.we == '0)
    ) else $error("lane enable high in state %s", state.name());

    // Release completes quickly once req drops
    a_ack_fall_after_req: assert property (
        @(posedge i_clk) disable iff (rst)
        $fell(req) |-> ##[1:2] !ack
    ) else $error("ack held after req fell");

endmodule

`default_nettype wire

//--- design/lane_buf_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "lane_buf_params.svh"

module lane_buf_top
    import lane_buf_cmd_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   rst,
    // Host handshake and command fields
    input  logic                   req,
    output logic                   ack,
    input  buf_op_e                op,
    input  logic [`LANE_AW-1:0]    addr,
    input  logic [`WORD_W-1:0]     wdata,
    input  logic [`LANE_COUNT-1:0] byte_en,
    input  logic [`LANE_AW:0]      len,
    output logic [`WORD_W-1:0]     rdata
);

    // Lane bundle between controller and RAM
    lane_mem_if u_mem_if ();

    // Command FSM
    lane_buf_ctrl u_ctrl (
        .i_clk   (i_clk),
        .rst     (rst),
        .req     (req),
        .ack     (ack),
        .op      (op),
        .addr    (addr),
        .wdata   (wdata),
        .byte_en (byte_en),
        .len     (len),
        .rdata   (rdata),
        .mem     (u_mem_if.ctrl)
    );

    // Four byte lanes
    quad_port_ram u_ram (
        .i_clk (i_clk),
        .rst   (rst),
        .mem   (u_mem_if.mem)
    );

endmodule

`default_nettype wire

//--- test/lane_buf_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "lane_buf_params.svh"

module lane_buf_tb
    import lane_buf_cmd_pkg::*;
();

    // Wait limits in clock cycles
    localparam int ACK_TIMEOUT = `LANE_DEPTH + 16;
    localparam int REL_TIMEOUT = 8;

    logic                   i_clk;
    logic                   rst;
    logic                   req;
    logic                   ack;
    buf_op_e                op;
    logic [`LANE_AW-1:0]    addr;
    logic [`WORD_W-1:0]     wdata;
    logic [`LANE_COUNT-1:0] byte_en;
    logic [`LANE_AW:0]      len;
    logic [`WORD_W-1:0]     rdata;

    // Reference model, one word per address
    logic [`WORD_W-1:0]     model_mem [0:`LANE_DEPTH-1];
    // Addresses written by the full-word test
    logic [`LANE_AW-1:0]    used_addr [0:7];
    logic [`WORD_W-1:0]     rnd;
    integer                 seed;
    int                     errors;
    int                     sva_errors;
    int                     err_mark;
    int                     n_pass;
    int                     n_fail;

    lane_buf_top DUT (
        .i_clk   (i_clk),
        .rst     (rst),
        .req     (req),
        .ack     (ack),
        .op      (op),
        .addr    (addr),
        .wdata   (wdata),
        .byte_en (byte_en),
        .len     (len),
        .rdata   (rdata)
    );

    // 100 ns clock
    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // ack has to drop within two edges of req falling
    a_ack_release: assert property (
        @(posedge i_clk) disable iff (rst)
        $fell(req) |-> ##[1:2] !ack
    ) else begin
        $display("ack stayed high more than two edges after req fell");
        sva_errors++;
    end

    // ==========================================================================
    // Model and bookkeeping
    // ==========================================================================

    // Edges from the sampling edge to ack high
    function automatic int expected_ack_edges(input buf_op_e o, input logic [`LANE_AW:0] n);
        if (o == OP_FILL) begin
            return int'(n) + 1;
        end
        return 2;
    endfunction

    // Byte-wise update, cleared enable keeps the old byte
    task automatic model_write(input logic [`LANE_AW-1:0] a, input logic [`WORD_W-1:0] d,
                               input logic [`LANE_COUNT-1:0] be);
        for (int b = 0; b < `LANE_COUNT; b++) begin
            if (be[b]) begin
                model_mem[a][b*`LANE_W +: `LANE_W] = d[b*`LANE_W +: `LANE_W];
            end
        end
    endtask

    task automatic finish_test(input string name);
        int total;
        total = errors + sva_errors;
        if (total == err_mark) begin
            $display("test %s: pass", name);
            n_pass++;
        end else begin
            $display("test %s: FAIL with %0d errors", name, total - err_mark);
            n_fail++;
        end
        err_mark = total;
    endtask

    // ==========================================================================
    // Host driver, four-phase handshake on falling edges
    // ==========================================================================

    task automatic run_cmd(
        input  string                  name,
        input  buf_op_e                c_op,
        input  logic [`LANE_AW-1:0]    c_addr,
        input  logic [`WORD_W-1:0]     c_wdata,
        input  logic [`LANE_COUNT-1:0] c_be,
        input  logic [`LANE_AW:0]      c_len,
        input  int                     hold,
        output logic [`WORD_W-1:0]     got
    );
        int edges;
        int exp_edges;
        exp_edges = expected_ack_edges(c_op, c_len);
        got       = '0;
        op        = c_op;
        addr      = c_addr;
        wdata     = c_wdata;
        byte_en   = c_be;
        len       = c_len;
        req       = 1'b1;
        // Count edges, the first one is where IDLE samples req
        edges = 0;
        while (!ack && edges < ACK_TIMEOUT) begin
            @(negedge i_clk);
            edges++;
        end
        if (!ack) begin
            $display("%s: ack never rose", name);
            errors++;
            req = 1'b0;
            repeat (REL_TIMEOUT) @(negedge i_clk);
        end else begin
            assert (edges - 1 == exp_edges) else begin
                $display("MISMATCH %s ack latency: expected %0d, actual %0d",
                         name, exp_edges, edges - 1);
                errors++;
            end
            got = rdata;
            // Back-pressure, ack must hold while req stays up
            for (int i = 0; i < hold; i++) begin
                @(negedge i_clk);
                assert (ack) else begin
                    $display("%s: ack dropped while req was held", name);
                    errors++;
                end
            end
            req   = 1'b0;
            edges = 0;
            while (ack && edges < REL_TIMEOUT) begin
                @(negedge i_clk);
                edges++;
            end
            if (ack) begin
                $display("%s: ack never fell after req dropped", name);
                errors++;
            end else begin
                assert (edges <= 2) else begin
                    $display("MISMATCH %s ack release: expected <= 2, actual %0d",
                             name, edges);
                    errors++;
                end
            end
            // Let the FSM pass through release back to idle
            @(negedge i_clk);
        end
    endtask

    task automatic write_word(input string name, input logic [`LANE_AW-1:0] a,
                              input logic [`WORD_W-1:0] d,
                              input logic [`LANE_COUNT-1:0] be, input int hold);
        logic [`WORD_W-1:0] got;
        run_cmd(name, OP_WRITE, a, d, be, '0, hold, got);
        model_write(a, d, be);
    endtask

    task automatic read_check(input string name, input logic [`LANE_AW-1:0] a,
                              input int hold);
        logic [`WORD_W-1:0] got;
        run_cmd(name, OP_READ, a, '0, '0, '0, hold, got);
        assert (got === model_mem[a]) else begin
            $display("MISMATCH %s at %0d: expected %h, actual %h", name, a, model_mem[a], got);
            errors++;
        end
    endtask

    task automatic fill_run(input string name, input logic [`LANE_AW-1:0] a,
                            input logic [`WORD_W-1:0] pat, input logic [`LANE_AW:0] n,
                            input int hold);
        logic [`WORD_W-1:0] got;
        int                 idx;
        run_cmd(name, OP_FILL, a, pat, '0, n, hold, got);
        // Run wraps modulo the lane depth
        for (int k = 0; k < int'(n); k++) begin
            idx = (int'(a) + k) % `LANE_DEPTH;
            model_mem[idx] = pat;
        end
    endtask

    // ==========================================================================
    // Test sequence
    // ==========================================================================

    initial begin
        seed       = 25;
        errors     = 0;
        sva_errors = 0;
        err_mark   = 0;
        n_pass     = 0;
        n_fail     = 0;
        rst        = 1'b1;
        req        = 1'b0;
        op         = OP_READ;
        addr       = '0;
        wdata      = '0;
        byte_en    = '0;
        len        = '0;
        repeat (4) @(negedge i_clk);
        rst = 1'b0;

        // Outputs cleared by reset
        assert (ack === 1'b0) else begin
            $display("MISMATCH reset ack: expected 0, actual %b", ack);
            errors++;
        end
        assert (rdata === '0) else begin
            $display("MISMATCH reset rdata: expected %h, actual %h", '0, rdata);
            errors++;
        end
        finish_test("reset");

        // Full words to random addresses
        for (int i = 0; i < 8; i++) begin
            rnd          = $random(seed);
            used_addr[i] = rnd[`LANE_AW-1:0];
            rnd          = $random(seed);
            write_word("full_write", used_addr[i], rnd, '1, 0);
        end
        for (int i = 0; i < 8; i++) begin
            read_check("full_write", used_addr[i], 0);
        end
        finish_test("full_write");

        // Random masks over known words
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            byte_en = rnd[`LANE_COUNT-1:0];
            rnd = $random(seed);
            write_word("masked_write", used_addr[i], rnd, byte_en, 0);
            read_check("masked_write", used_addr[i], 0);
        end
        finish_test("masked_write");

        // Run 508 through 2 wraps past the top, 507 and 3 stay
        rnd = $random(seed);
        write_word("fill_wrap", 9'd507, rnd, '1, 0);
        rnd = $random(seed);
        write_word("fill_wrap", 9'd3, rnd, '1, 0);
        rnd = $random(seed);
        fill_run("fill_wrap", 9'd508, rnd, 10'd7, 0);
        read_check("fill_wrap", 9'd507, 0);
        read_check("fill_wrap", 9'd508, 0);
        read_check("fill_wrap", 9'd511, 0);
        read_check("fill_wrap", 9'd0, 0);
        read_check("fill_wrap", 9'd2, 0);
        read_check("fill_wrap", 9'd3, 0);
        finish_test("fill_wrap");

        // Zero length leaves the target alone
        rnd = $random(seed);
        write_word("fill_zero", 9'd100, rnd, '1, 0);
        rnd = $random(seed);
        fill_run("fill_zero", 9'd100, rnd, 10'd0, 0);
        read_check("fill_zero", 9'd100, 0);
        finish_test("fill_zero");

        // Held req on each command kind
        read_check("handshake", used_addr[0], 5);
        // Known word first, so the masked lanes have bytes to keep
        rnd = $random(seed);
        write_word("handshake", 9'd200, rnd, '1, 0);
        rnd = $random(seed);
        write_word("handshake", 9'd200, rnd, 4'b0101, 5);
        read_check("handshake", 9'd200, 0);
        rnd = $random(seed);
        write_word("handshake", 9'd303, rnd, '1, 0);
        rnd = $random(seed);
        fill_run("handshake", 9'd300, rnd, 10'd3, 4);
        read_check("handshake", 9'd302, 0);
        read_check("handshake", 9'd303, 0);
        finish_test("handshake");

        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0 && errors + sva_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lane_buf.f
+incdir+common
common/lane_buf_cmd_pkg.sv
common/lane_buf_ctrl_pkg.sv
common/lane_mem_if.sv
memory/quad_port_ram.sv
design/lane_buf_ctrl.sv
design/lane_buf_top.sv
test/lane_buf_tb.sv

//--- Makefile
# Verilator simulation of the lane buffer

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = lane_buf_tb
FLIST     = lane_buf.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test passed

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
